// File: src.f
source/cyc_pkg.sv
source/n_delay.sv
source/sdpram.sv
source/cyclic_cfg_regs.sv
source/always_valid_cyclic_bram.sv
source/cyclic_buffer_top.sv
verif/tb_cyclic_buffer.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module tb_cyclic_buffer \
  && ./obj_dir/Vtb_cyclic_buffer > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && exit 1
exit 0

// File: verif/tb_cyclic_buffer.sv
module tb_cyclic_buffer;
  timeunit 1ns;
  timeprecision 100ps;

  import cyc_pkg::*;

  localparam int DEPTH = 8;
  localparam int WIDTH = 64;
  // all six tests together stay well below 2500 cycles.
  localparam int MAX_CYCLES = 4000;

  typedef logic [WIDTH-1:0] word_t;

  logic     clk;
  logic     arst_n;
  cfg_req_t cfg;
  logic     s_valid_ready;
  word_t    s_data;
  logic     m_ready;
  logic     m_valid;
  word_t    m_data;

  integer seed          = 32'hcce0_7841;
  int     err_cnt       = 0;
  int     model_err_cnt = 0;
  int     cycle_cnt     = 0;
  string  test_name     = "reset";

  // reference model of the loaded words and the replay position.
  word_t words [DEPTH];
  int    model_len    = DEPTH;
  logic  model_on     = 1'b0;
  logic  model_was_on = 1'b0;
  logic  run_model    = 1'b0;
  logic  accept;
  int    idx          = 0;
  int    beat_cnt     = 0;
  logic  prev_valid   = 1'b0;
  logic  prev_beat    = 1'b0;
  word_t prev_data    = '0;

  cyclic_buffer_top dut0 (
    .clk           (clk),
    .arst_n        (arst_n),
    .cfg           (cfg),
    .s_valid_ready (s_valid_ready),
    .s_data        (s_data),
    .m_ready       (m_ready),
    .m_valid       (m_valid),
    .m_data        (m_data)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return lo + (r % (hi - lo + 1));
  endfunction

  function automatic logic rand_bit();
    int r;
    r = $random(seed);
    return r[0];
  endfunction

  function automatic word_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
    err_cnt++;
    $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
  endtask

  task automatic end_run(input bit timed_out);
    $display("errors: %0d in sequence checks, %0d in model checks", err_cnt, model_err_cnt);
    if (!timed_out && err_cnt == 0 && model_err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  // the register takes the write on the second edge.
  task automatic cfg_write(input cfg_sel_e sel, input int value);
    @(posedge clk);
    cfg.we   <= 1'b1;
    cfg.sel  <= sel;
    cfg.data <= cfg_data_t'(value);
    @(posedge clk);
    cfg.we <= 1'b0;
  endtask

  task automatic load_words(input int count, input bit random_ready);
    int    gap;
    word_t w;
    for (int i = 0; i < count; i++) begin
      gap = rand_range(0, 3);
      repeat (gap) begin
        @(posedge clk);
        s_valid_ready <= 1'b0;
        if (random_ready) begin
          m_ready <= rand_bit();
        end
        @(negedge clk);
        if (m_valid !== 1'b0) begin
          report_mismatch(test_name, word_t'(0), word_t'(m_valid));
        end
      end
      w        = rand_word();
      words[i] = w;
      @(posedge clk);
      s_valid_ready <= 1'b1;
      s_data        <= w;
      if (random_ready) begin
        m_ready <= rand_bit();
      end
      @(negedge clk);
      if (m_valid !== 1'b0) begin
        report_mismatch(test_name, word_t'(0), word_t'(m_valid));
      end
    end
    // this edge takes the last word, so valid rises here.
    @(posedge clk);
    s_valid_ready <= 1'b0;
    model_len     = count;
    model_on      = 1'b1;
    @(negedge clk);
    if (m_valid !== 1'b1) begin
      report_mismatch(test_name, word_t'(1), word_t'(m_valid));
    end
  endtask

  task automatic wait_beats(input int count, input bit random_ready);
    int target;
    @(posedge clk);
    target = beat_cnt + count;
    while (beat_cnt < target) begin
      m_ready <= random_ready ? rand_bit() : 1'b1;
      @(posedge clk);
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      end_run(1'b1);
    end
  end

  // outputs are compared at the falling edge, half a cycle after they change.
  always @(negedge clk) begin
    if (model_on && !model_was_on) begin
      idx        = 0;
      prev_valid = 1'b0;
      prev_beat  = 1'b0;
    end
    model_was_on = model_on;
    if (model_on) begin
      if (!m_valid) begin
        model_err_cnt++;
        $display("ERROR: m_valid went low during replay in test %s", test_name);
      end else begin
        if (m_data !== words[idx]) begin
          model_err_cnt++;
          $display("CHECK FAILED %s: expected %0h, actual %0h", test_name, words[idx], m_data);
        end
        if (prev_valid && !prev_beat && m_data !== prev_data) begin
          model_err_cnt++;
          $display("CHECK FAILED stall_hold: expected %0h, actual %0h", prev_data, m_data);
        end
      end
      // a beat needs the clock enable, which follows the run bit.
      accept = m_valid && m_ready && run_model;
      if (accept) begin
        idx = (idx == model_len - 1) ? 0 : idx + 1;
        beat_cnt++;
      end
      prev_valid = m_valid;
      prev_beat  = accept;
      prev_data  = m_data;
    end
    if (!arst_n) begin
      run_model = 1'b0;
    end else if (cfg.we && cfg.sel == CFG_RUN) begin
      run_model = cfg.data[0];
    end
  end

  initial begin
    int    start_beats;
    int    pause_len;
    word_t held;
    arst_n        = 1'b0;
    cfg           = '0;
    s_valid_ready = 1'b0;
    s_data        = '0;
    m_ready       = 1'b0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    test_name = "reset";
    repeat (2) begin
      @(negedge clk);
      if (m_valid !== 1'b0) begin
        report_mismatch(test_name, word_t'(0), word_t'(m_valid));
      end
    end

    test_name = "load_valid";
    cfg_write(CFG_LENGTH, 5);
    cfg_write(CFG_RUN, 1);
    load_words(6, 1'b0);

    // every cycle should carry one beat.
    test_name = "replay";
    @(posedge clk);
    m_ready     <= 1'b1;
    start_beats = beat_cnt;
    repeat (40) @(posedge clk);
    if (beat_cnt - start_beats != 40) begin
      report_mismatch("replay_rate", word_t'(40), word_t'(beat_cnt - start_beats));
    end

    test_name = "backpressure";
    repeat (300) begin
      @(posedge clk);
      m_ready <= rand_bit();
    end

    test_name = "pause";
    pause_len = rand_range(5, 20);
    @(posedge clk);
    m_ready <= 1'b1;
    cfg_write(CFG_RUN, 0);
    @(negedge clk);
    held = m_data;
    repeat (pause_len) begin
      @(negedge clk);
      if (m_data !== held) begin
        report_mismatch("pause_hold", held, m_data);
      end
    end
    cfg_write(CFG_RUN, 1);
    wait_beats(20, 1'b0);

    test_name = "full_depth";
    @(posedge clk);
    model_on = 1'b0;
    m_ready  <= 1'b0;
    arst_n   <= 1'b0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    if (m_valid !== 1'b0) begin
      report_mismatch("reset_again", word_t'(0), word_t'(m_valid));
    end
    cfg_write(CFG_LENGTH, DEPTH - 1);
    cfg_write(CFG_RUN, 1);
    load_words(DEPTH, 1'b1);
    wait_beats(200, 1'b1);

    @(posedge clk);
    end_run(1'b0);
  end

endmodule

// File: source/cyclic_buffer_top.sv
module cyclic_buffer_top #(
  parameter int DEPTH   = 8,
  parameter int WIDTH   = 64,
  parameter int LATENCY = 3
) (
  input  logic              clk,
  input  logic              arst_n,
  input  cyc_pkg::cfg_req_t cfg,
  input  logic              s_valid_ready,
  input  logic [WIDTH-1:0]  s_data,
  input  logic              m_ready,
  output logic              m_valid,
  output logic [WIDTH-1:0]  m_data
);
  localparam int ADDR_W = $clog2(DEPTH);

  logic [ADDR_W-1:0] addr_max_1;
  logic              clken;
  logic              ram_we;
  logic [ADDR_W-1:0] ram_waddr;
  logic [WIDTH-1:0]  ram_wdata;
  logic [ADDR_W-1:0] ram_raddr;
  logic [WIDTH-1:0]  ram_rdata;

  cyclic_cfg_regs #(
    .DEPTH   (DEPTH),
    .LATENCY (LATENCY)
  ) u_cfg_regs (
    .clk        (clk),
    .arst_n     (arst_n),
    .cfg        (cfg),
    .addr_max_1 (addr_max_1),
    .clken      (clken)
  );

  always_valid_cyclic_bram #(
    .DEPTH   (DEPTH),
    .WIDTH   (WIDTH),
    .LATENCY (LATENCY)
  ) u_replay (
    .clk           (clk),
    .clken         (clken),
    .arst_n        (arst_n),
    .s_valid_ready (s_valid_ready),
    .s_data        (s_data),
    .m_ready       (m_ready),
    .addr_max_1    (addr_max_1),
    .ram_rdata     (ram_rdata),
    .m_valid       (m_valid),
    .m_data        (m_data),
    .ram_we        (ram_we),
    .ram_waddr     (ram_waddr),
    .ram_wdata     (ram_wdata),
    .ram_raddr     (ram_raddr)
  );

  sdpram #(
    .DEPTH   (DEPTH),
    .WIDTH   (WIDTH),
    .LATENCY (LATENCY)
  ) u_ram (
    .clk    (clk),
    .arst_n (arst_n),
    .clken  (clken),
    .wea    (ram_we),
    .addra  (ram_waddr),
    .dina   (ram_wdata),
    .addrb  (ram_raddr),
    .doutb  (ram_rdata)
  );

endmodule

// File: source/always_valid_cyclic_bram.sv
module always_valid_cyclic_bram #(
  parameter int DEPTH   = 8,
  parameter int WIDTH   = 64,
  parameter int LATENCY = 3
) (
  input  logic                     clk,
  input  logic                     clken,
  input  logic                     arst_n,
  input  logic                     s_valid_ready,
  input  logic [WIDTH-1:0]         s_data,
  input  logic                     m_ready,
  input  logic [$clog2(DEPTH)-1:0] addr_max_1,
  input  logic [WIDTH-1:0]         ram_rdata,
  output logic                     m_valid,
  output logic [WIDTH-1:0]         m_data,
  output logic                     ram_we,
  output logic [$clog2(DEPTH)-1:0] ram_waddr,
  output logic [WIDTH-1:0]         ram_wdata,
  output logic [$clog2(DEPTH)-1:0] ram_raddr
);
  import cyc_pkg::*;

  localparam int BUF_DEPTH = LATENCY + 1;
  localparam int ADDR_W    = $clog2(DEPTH);
  localparam int PTR_W     = $clog2(BUF_DEPTH);

  typedef logic [WIDTH-1:0]  word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [PTR_W-1:0]  ptr_t;

  buf_state_e state_q;
  buf_state_e state_d;
  addr_t      waddr_q;
  addr_t      raddr_q;
  addr_t      first_raddr;
  ptr_t       w_ptr_q;
  ptr_t       r_ptr_q;
  word_t      skid [BUF_DEPTH];
  word_t      skid_wdata;
  logic       skid_we;
  logic       w_ptr_last;
  logic       beat;
  logic       ram_valid;
  logic       last_write;

  assign beat       = m_valid && m_ready;
  assign last_write = s_valid_ready && (waddr_q == addr_max_1);
  assign w_ptr_last = (w_ptr_q == ptr_t'(BUF_DEPTH - 1));

  // words 0 to LATENCY sit in the skid store, so replay reads start after them.
  // a sequence of exactly LATENCY+1 words wraps straight back to 0.
  assign first_raddr = (addr_max_1 == addr_t'(LATENCY)) ? '0 : addr_t'(BUF_DEPTH);

  always_comb begin
    state_d    = state_q;
    skid_we    = 1'b0;
    skid_wdata = ram_rdata;
    case (state_q)
      IDLE: begin
        skid_we    = s_valid_ready;
        skid_wdata = s_data;
        if (s_valid_ready && w_ptr_last) begin
          state_d = WORK;
        end
      end
      WORK: begin
        skid_we = ram_valid;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= IDLE;
      w_ptr_q <= '0;
    end else if (clken) begin
      state_q <= state_d;
      if (skid_we) begin
        w_ptr_q <= w_ptr_last ? '0 : w_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clken && skid_we) begin
      skid[w_ptr_q] <= skid_wdata;
    end
  end

  // load side address counts from 0.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      waddr_q <= '0;
    end else if (clken && s_valid_ready) begin
      waddr_q <= (waddr_q == addr_max_1) ? '0 : waddr_q + 1'b1;
    end
  end

  // each accepted beat takes one RAM read and frees one skid slot.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      raddr_q <= addr_t'(BUF_DEPTH);
      r_ptr_q <= '0;
    end else if (clken) begin
      if (last_write) begin
        raddr_q <= first_raddr;
      end else if (beat) begin
        raddr_q <= (raddr_q == addr_max_1) ? '0 : raddr_q + 1'b1;
      end
      if (beat) begin
        r_ptr_q <= (r_ptr_q == ptr_t'(BUF_DEPTH - 1)) ? '0 : r_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid <= 1'b0;
    end else if (clken && last_write) begin
      m_valid <= 1'b1;
    end
  end

  // marks the cycle where the word read for a beat leaves the RAM.
  n_delay #(
    .N          (LATENCY),
    .DATA_WIDTH (1)
  ) u_rd_valid (
    .clk      (clk),
    .arst_n   (arst_n),
    .clken    (clken),
    .data_in  (beat),
    .data_out (ram_valid)
  );

  assign m_data    = skid[r_ptr_q];
  assign ram_we    = s_valid_ready;
  assign ram_waddr = waddr_q;
  assign ram_wdata = s_data;
  assign ram_raddr = raddr_q;

  // a refill must never land in the slot that is on the output.
  a_hold_on_stall: assert property (
    @(posedge clk) disable iff (!arst_n)
    m_valid && !(clken && m_ready) |=> $stable(m_data)
  ) else begin
    $error("m_data changed while the output was stalled");
  end

  // reloading needs a reset first.
  a_no_load_in_replay: assert property (
    @(posedge clk) disable iff (!arst_n)
    m_valid |-> !s_valid_ready
  ) else begin
    $error("load strobe seen during replay");
  end

endmodule

// File: source/cyclic_cfg_regs.sv
module cyclic_cfg_regs #(
  parameter int DEPTH   = 8,
  parameter int LATENCY = 3
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  cyc_pkg::cfg_req_t        cfg,
  output logic [$clog2(DEPTH)-1:0] addr_max_1,
  output logic                     clken
);
  import cyc_pkg::*;

  localparam int ADDR_W = $clog2(DEPTH);

  typedef logic [ADDR_W-1:0] addr_t;

  // sequence length minus one, which is the last replayed address.
  addr_t len_m1_q;
  logic  run_q;

  // writes land even while stopped, so run can be set again.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      len_m1_q <= addr_t'(DEPTH - 1);
      run_q    <= 1'b0;
    end else if (cfg.we) begin
      case (cfg.sel)
        CFG_LENGTH: begin
          len_m1_q <= cfg.data[ADDR_W-1:0];
        end
        CFG_RUN: begin
          run_q <= cfg.data[0];
        end
      endcase
    end
  end

  assign addr_max_1 = len_m1_q;
  assign clken      = run_q;

  // the skid store needs LATENCY+1 words and the RAM holds DEPTH of them.
  a_len_range: assert property (
    @(posedge clk) disable iff (!arst_n)
    cfg.we && (cfg.sel == CFG_LENGTH) |->
      (cfg.data >= CFG_DATA_W'(LATENCY)) && (cfg.data <= CFG_DATA_W'(DEPTH - 1))
  ) else begin
    $error("sequence length write %0d out of range", cfg.data);
  end

endmodule

// File: source/sdpram.sv
module sdpram #(
  parameter int DEPTH   = 8,
  parameter int WIDTH   = 64,
  parameter int LATENCY = 3
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     clken,
  input  logic                     wea,
  input  logic [$clog2(DEPTH)-1:0] addra,
  input  logic [WIDTH-1:0]         dina,
  input  logic [$clog2(DEPTH)-1:0] addrb,
  output logic [WIDTH-1:0]         doutb
);
  typedef logic [WIDTH-1:0] word_t;

  word_t mem [DEPTH];
  word_t rd_q;

  // array read is the first of the LATENCY stages.
  always_ff @(posedge clk) begin
    if (clken) begin
      if (wea) begin
        mem[addra] <= dina;
      end
      rd_q <= mem[addrb];
    end
  end

  // output pipeline registers of the block RAM.
  n_delay #(
    .N          (LATENCY - 1),
    .DATA_WIDTH (WIDTH)
  ) u_out_pipe (
    .clk      (clk),
    .arst_n   (arst_n),
    .clken    (clken),
    .data_in  (rd_q),
    .data_out (doutb)
  );

endmodule

// File: source/n_delay.sv
module n_delay #(
  parameter int N          = 1,
  parameter int DATA_WIDTH = 1
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  clken,
  input  logic [DATA_WIDTH-1:0] data_in,
  output logic [DATA_WIDTH-1:0] data_out
);
  typedef logic [DATA_WIDTH-1:0] word_t;

  if (N == 0) begin : g_pass
    assign data_out = data_in;
  end else begin : g_chain
    word_t stage [N];

    // stage 0 takes the input, the last stage is the output.
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        for (int i = 0; i < N; i++) begin
          stage[i] <= '0;
        end
      end else if (clken) begin
        stage[0] <= data_in;
        for (int i = 1; i < N; i++) begin
          stage[i] <= stage[i-1];
        end
      end
    end

    assign data_out = stage[N-1];
  end

endmodule

// File: source/cyc_pkg.sv
package cyc_pkg;

  localparam int CFG_DATA_W = 16;

  // raw data word of one configuration write.
  typedef logic [CFG_DATA_W-1:0] cfg_data_t;

  typedef enum logic {
    CFG_LENGTH = 1'b0,
    CFG_RUN    = 1'b1
  } cfg_sel_e;

  typedef struct packed {
    logic      we;
    cfg_sel_e  sel;
    cfg_data_t data;
  } cfg_req_t;

  // IDLE pre-fills the skid store, WORK refills it from the RAM.
  typedef enum logic {
    IDLE = 1'b0,
    WORK = 1'b1
  } buf_state_e;

endpackage
